// ==== flist.f ====
+incdir+test
rtl/yuv420_pkg.sv
rtl/uv_line_buffer.sv
rtl/chroma_kernel.sv
rtl/stream_packer.sv
rtl/yuv420_packer_top.sv
test/tb_yuv420_packer.sv

// ==== test/yuv420_model.svh ====
// packing mode of a frame
localparam int mode_raw = 0;
localparam int mode_yuv = 1;
localparam int mode_420 = 2;

// largest frame the tests generate
localparam int frame_max_rows = 6;
localparam int frame_max_cols = 8;

// frame under test indexed by row and column
logic [7:0]  frame_y   [frame_max_rows][frame_max_cols];
logic [7:0]  frame_u   [frame_max_rows][frame_max_cols];
logic [7:0]  frame_v   [frame_max_rows][frame_max_cols];
logic [15:0] frame_raw [frame_max_rows][frame_max_cols];

// expected output items with the oldest first
yuv420_pkg::dtype_t                exp_dtype [$];
logic [yuv420_pkg::word_width-1:0] exp_data  [$];

// bytes not yet gathered into a word
logic [7:0] pending [$];

function automatic void make_frame(input int rows, input int cols);
   for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
         frame_y[r][c]   = 8'($urandom);
         frame_u[r][c]   = 8'($urandom);
         frame_v[r][c]   = 8'($urandom);
         frame_raw[r][c] = 16'($urandom);
      end
   end
endfunction

// mean of four samples rounded down
function automatic logic [7:0] floor_ave(input logic [7:0] a, input logic [7:0] b,
                                         input logic [7:0] c, input logic [7:0] d);
   int sum;
   sum = int'(a) + int'(b) + int'(c) + int'(d);
   return 8'(sum / 4);
endfunction

function automatic void add_expected(input yuv420_pkg::dtype_t dtype,
                                     input logic [yuv420_pkg::word_width-1:0] data);
   exp_dtype.push_back(dtype);
   exp_data.push_back(data);
endfunction

// first byte of a word lands in the low lane
function automatic void append_byte(input logic [7:0] b);
   pending.push_back(b);
   if (pending.size() == 4) begin
      add_expected(yuv420_pkg::dtype_pixel, {pending[3], pending[2], pending[1], pending[0]});
      pending.delete();
   end
endfunction

function automatic void build_expected(input int rows, input int cols, input int mode);
   logic [yuv420_pkg::word_width-1:0] last_word;
   pending.delete();
   add_expected(yuv420_pkg::dtype_frame_start, '0);
   for (int r = 0; r < rows; r++) begin
      add_expected(yuv420_pkg::dtype_row_start, '0);
      for (int c = 0; c < cols; c++) begin
         if (mode == mode_raw) begin
            append_byte(frame_raw[r][c][15:8]);
         end else if (mode == mode_yuv) begin
            append_byte(frame_y[r][c]);
            append_byte(frame_u[r][c]);
            append_byte(frame_v[r][c]);
         end else begin
            append_byte(frame_y[r][c]);
            // bottom right pixel of each 2x2 block carries the chroma
            if ((r % 2 == 1) && (c % 2 == 1)) begin
               append_byte(floor_ave(frame_u[r-1][c-1], frame_u[r-1][c],
                                     frame_u[r][c-1], frame_u[r][c]));
               append_byte(floor_ave(frame_v[r-1][c-1], frame_v[r-1][c],
                                     frame_v[r][c-1], frame_v[r][c]));
            end
         end
      end
      add_expected(yuv420_pkg::dtype_row_end, '0);
   end
   // leftover bytes go out zero padded and frame end repeats that word
   if (pending.size() != 0) begin
      last_word = '0;
      for (int i = 0; i < pending.size(); i++) begin
         last_word[8*i +: 8] = pending[i];
      end
      add_expected(yuv420_pkg::dtype_pixel, last_word);
      add_expected(yuv420_pkg::dtype_frame_end, last_word);
      pending.delete();
   end else begin
      add_expected(yuv420_pkg::dtype_frame_end, '0);
   end
endfunction

// ==== test/tb_yuv420_packer.sv ====
`timescale 1ns/100ps

module tb_yuv420_packer;

   localparam int num_frames = 24;

   logic                              clk;
   logic                              resetb;
   logic                              dvi;
   yuv420_pkg::pixel_in_t             pixel_in;
   logic                              raw_mode;
   logic                              enable_420;
   logic                              dvo;
   yuv420_pkg::dtype_t                dtypeo;
   logic [yuv420_pkg::word_width-1:0] datao;

   `include "yuv420_model.svh"

   // frame sizes and modes picked before the run starts
   int frame_rows [num_frames];
   int frame_cols [num_frames];
   int frame_mode [num_frames];
   int total_items;
   int cycle_limit;
   int cycle_cnt;
   int item_idx;

   yuv420_packer_top yuv420_packer_top_i (
      .clk        (clk),
      .resetb     (resetb),
      .dvi        (dvi),
      .pixel_in   (pixel_in),
      .raw_mode   (raw_mode),
      .enable_420 (enable_420),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao)
   );

   always #2 clk = ~clk;

   task automatic stop_on_error();
      $display("Finished with errors");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic compare_dtype(input int idx, input yuv420_pkg::dtype_t got,
                                input yuv420_pkg::dtype_t exp);
      if (got !== exp) begin
         $display("Fail at %0t: item %0d dtype %0d, expected %0d", $time, idx, got, exp);
         stop_on_error();
      end
   endtask

   task automatic compare_word(input int idx, input logic [yuv420_pkg::word_width-1:0] got,
                               input logic [yuv420_pkg::word_width-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: item %0d data %08h, expected %08h", $time, idx, got, exp);
         stop_on_error();
      end
   endtask

   // even sizes in yuv420 so every 2x2 block is complete
   task automatic pick_frame_sizes();
      total_items = 0;
      for (int f = 0; f < num_frames; f++) begin
         frame_mode[f] = f % 3;
         if (frame_mode[f] == mode_420) begin
            frame_cols[f] = 2 * (1 + ($urandom % 4));
            frame_rows[f] = 2 * (1 + ($urandom % 3));
         end else begin
            frame_cols[f] = 2 + ($urandom % 7);
            frame_rows[f] = 2 + ($urandom % 5);
         end
         total_items += 2 + frame_rows[f] * (frame_cols[f] + 2);
      end
      cycle_limit = 4 * total_items + 200;
   endtask

   task automatic drive_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         dvi = 1'b0;
      end
   endtask

   // random idle gap and then one item
   task automatic drive_item(input yuv420_pkg::pixel_in_t item);
      drive_idle($urandom % 3);
      @(negedge clk);
      dvi      = 1'b1;
      pixel_in = item;
   endtask

   task automatic drive_frame(input int rows, input int cols, input int mode);
      yuv420_pkg::pixel_in_t item;
      raw_mode   = (mode == mode_raw);
      enable_420 = (mode == mode_420);
      make_frame(rows, cols);
      build_expected(rows, cols, mode);
      item       = '0;
      item.dtype = yuv420_pkg::dtype_frame_start;
      drive_item(item);
      for (int r = 0; r < rows; r++) begin
         item.dtype = yuv420_pkg::dtype_row_start;
         drive_item(item);
         for (int c = 0; c < cols; c++) begin
            item.dtype = yuv420_pkg::dtype_pixel;
            item.y     = frame_y[r][c];
            item.u     = frame_u[r][c];
            item.v     = frame_v[r][c];
            item.raw   = frame_raw[r][c];
            drive_item(item);
         end
         item       = '0;
         item.dtype = yuv420_pkg::dtype_row_end;
         drive_item(item);
      end
      item.dtype = yuv420_pkg::dtype_frame_end;
      drive_item(item);
      // the flush needs an idle cycle after frame end
      drive_idle(2 + ($urandom % 2));
   endtask

   // output monitor checks the order but not the cycle
   always @(negedge clk) begin
      if (resetb && dvo) begin
         if (exp_dtype.size() == 0) begin
            $display("output item %0d at %0t was not expected", item_idx, $time);
            stop_on_error();
         end else begin
            compare_dtype(item_idx, dtypeo, exp_dtype.pop_front());
            compare_word(item_idx, datao, exp_data.pop_front());
            item_idx++;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("timeout after %0d cycles, %0d output items still missing",
                  cycle_cnt, exp_dtype.size());
         stop_on_error();
      end
   end

   initial begin
      void'($urandom(32'h33d21351));
      clk        = 1'b0;
      resetb     = 1'b0;
      dvi        = 1'b0;
      pixel_in   = '0;
      raw_mode   = 1'b0;
      enable_420 = 1'b0;
      cycle_cnt  = 0;
      item_idx   = 0;
      pick_frame_sizes();
      repeat (2) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
      drive_idle(2);
      for (int f = 0; f < num_frames; f++) begin
         drive_frame(frame_rows[f], frame_cols[f], frame_mode[f]);
      end
      while (exp_dtype.size() != 0) begin
         @(negedge clk);
      end
      // quiet period to catch stray output items
      drive_idle(20);
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== rtl/yuv420_packer_top.sv ====
`timescale 1ns/100ps

module yuv420_packer_top (
   input  logic                              clk,
   input  logic                              resetb,
   input  logic                              dvi,
   input  yuv420_pkg::pixel_in_t             pixel_in,
   input  logic                              raw_mode,
   input  logic                              enable_420,
   output logic                              dvo,
   output yuv420_pkg::dtype_t                dtypeo,
   output logic [yuv420_pkg::word_width-1:0] datao
);

   // kernel stage to packer
   logic                    kv;
   yuv420_pkg::kernel_out_t kout;

   // register stage, phase tracking and 2x2 chroma averages
   chroma_kernel u_chroma_kernel (
      .clk      (clk),
      .resetb   (resetb),
      .dvi      (dvi),
      .pixel_in (pixel_in),
      .kv       (kv),
      .kout     (kout)
   );

   // byte packing into 32-bit words, flush at frame end
   stream_packer u_stream_packer (
      .clk        (clk),
      .resetb     (resetb),
      .kv         (kv),
      .kout       (kout),
      .raw_mode   (raw_mode),
      .enable_420 (enable_420),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao)
   );

endmodule

// ==== rtl/stream_packer.sv ====
`timescale 1ns/100ps

module stream_packer (
   input  logic                              clk,
   input  logic                              resetb,
   input  logic                              kv,
   input  yuv420_pkg::kernel_out_t           kout,
   input  logic                              raw_mode,
   input  logic                              enable_420,
   output logic                              dvo,
   output yuv420_pkg::dtype_t                dtypeo,
   output logic [yuv420_pkg::word_width-1:0] datao
);

   localparam int obw = yuv420_pkg::obuf_width;
   localparam int fw  = yuv420_pkg::fill_width;

   logic [obw-1:0]                     obuf;
   logic [fw-1:0]                      opos;
   logic [obw-1:0]                     next_obuf;
   logic [fw-1:0]                      next_opos;
   logic [fw-1:0]                      next_opos2;
   logic [obw-1:0]                     word_shift;
   logic [yuv420_pkg::word_width-1:0]  word;
   logic [yuv420_pkg::word_width-1:0]  word_swap;
   logic [15:0]                        raw_shift;
   logic [7:0]                         raw_byte;
   logic                               pixel_valid;
   logic                               flush_req;
   logic                               flushed;

   assign pixel_valid = kv && (kout.dtype == yuv420_pkg::dtype_pixel);
   // frame end with bytes left over in the buffer
   assign flush_req   = kv && (kout.dtype == yuv420_pkg::dtype_frame_end) && (opos != '0);

   assign raw_shift = kout.raw >> yuv420_pkg::raw_pixel_shift;
   assign raw_byte  = raw_shift[7:0];

   // newest byte enters at the bottom and the oldest sits at bit opos-1
   always_comb begin
      next_obuf = obuf;
      next_opos = opos;
      if (flush_req) begin
         // move the leftover bytes to the top of the word with zeros below
         next_obuf = obuf << (fw'(yuv420_pkg::word_width) - opos);
         next_opos = fw'(yuv420_pkg::word_width);
      end else if (raw_mode) begin
         next_obuf = {obuf[obw-9:0], raw_byte};
         next_opos = opos + fw'(8);
      end else if (!enable_420) begin
         next_obuf = {obuf[obw-25:0], kout.y, kout.u, kout.v};
         next_opos = opos + fw'(24);
      end else if (kout.dump_uv) begin
         next_obuf = {obuf[obw-25:0], kout.y, kout.u_ave, kout.v_ave};
         next_opos = opos + fw'(24);
      end else begin
         // u and v dropped on this pixel
         next_obuf = {obuf[obw-9:0], kout.y};
         next_opos = opos + fw'(8);
      end
   end

   // oldest 32 bits of the buffer with the first byte in the low lane
   assign next_opos2 = next_opos - fw'(yuv420_pkg::word_width);
   assign word_shift = next_obuf >> next_opos2;
   assign word       = word_shift[yuv420_pkg::word_width-1:0];
   assign word_swap  = {word[7:0], word[15:8], word[23:16], word[31:24]};

   always_ff @(posedge clk) begin
      if (pixel_valid || flush_req) begin
         obuf <= next_obuf;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo     <= 1'b0;
         dtypeo  <= yuv420_pkg::dtype_frame_start;
         datao   <= '0;
         opos    <= '0;
         flushed <= 1'b0;
      end else begin
         flushed <= flush_req;
         if (pixel_valid || flush_req) begin
            // the flush word goes out tagged as a pixel
            dtypeo <= yuv420_pkg::dtype_pixel;
            if (next_opos >= fw'(yuv420_pkg::word_width)) begin
               dvo   <= 1'b1;
               datao <= word_swap;
               opos  <= next_opos2;
            end else begin
               dvo  <= 1'b0;
               opos <= next_opos;
            end
         end else if (flushed) begin
            // delayed frame end keeps the flushed word on datao
            dvo    <= 1'b1;
            dtypeo <= yuv420_pkg::dtype_frame_end;
         end else if (kv) begin
            // markers pass through with zero data
            dvo    <= 1'b1;
            dtypeo <= kout.dtype;
            datao  <= '0;
            if (kout.dtype == yuv420_pkg::dtype_frame_start) begin
               opos <= '0;
            end
         end else begin
            dvo   <= 1'b0;
            datao <= '0;
         end
      end
   end

endmodule

// ==== rtl/chroma_kernel.sv ====
`timescale 1ns/100ps

module chroma_kernel (
   input  logic                    clk,
   input  logic                    resetb,
   input  logic                    dvi,
   input  yuv420_pkg::pixel_in_t   pixel_in,
   output logic                    kv,
   output yuv420_pkg::kernel_out_t kout
);

   logic [yuv420_pkg::col_width-1:0] col_cnt;
   logic [yuv420_pkg::col_width-1:0] col_q;
   yuv420_pkg::pixel_in_t            item_q;
   logic                             row_phase;
   logic                             col_phase;
   logic                             item_is_pixel;
   logic                             wr_en;
   yuv420_pkg::uv_t                  wr_uv;
   yuv420_pkg::uv_t                  rd_uv;
   yuv420_pkg::uv_t                  left_uv;
   yuv420_pkg::uv_t                  up_left_uv;
   logic [9:0]                       u_sum;
   logic [9:0]                       v_sum;

   // column of the incoming pixel, used to look up the row above
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col_cnt <= '0;
      end else if (dvi) begin
         if (pixel_in.dtype == yuv420_pkg::dtype_row_start) begin
            col_cnt <= '0;
         end else if (pixel_in.dtype == yuv420_pkg::dtype_pixel) begin
            col_cnt <= col_cnt + 1'b1;
         end
      end
   end

   // input register stage
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         kv <= 1'b0;
      end else begin
         kv <= dvi;
      end
   end

   always_ff @(posedge clk) begin
      if (dvi) begin
         item_q <= pixel_in;
         col_q  <= col_cnt;
      end
   end

   assign item_is_pixel = kv && (item_q.dtype == yuv420_pkg::dtype_pixel);

   // row and column phase of the item in the register stage
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_phase <= 1'b0;
         col_phase <= 1'b0;
      end else if (kv) begin
         if (item_q.dtype == yuv420_pkg::dtype_frame_start) begin
            row_phase <= 1'b0;
         end else if (item_q.dtype == yuv420_pkg::dtype_row_end) begin
            row_phase <= !row_phase;
         end
         if (item_q.dtype == yuv420_pkg::dtype_row_start) begin
            col_phase <= 1'b0;
         end else if (item_q.dtype == yuv420_pkg::dtype_pixel) begin
            col_phase <= !col_phase;
         end
      end
   end

   // write back the current pixel one cycle after its read
   assign wr_en   = item_is_pixel;
   assign wr_uv.u = item_q.u;
   assign wr_uv.v = item_q.v;

   uv_line_buffer u_line_buffer (
      .clk    (clk),
      .resetb (resetb),
      .wr_en  (wr_en),
      .col    (col_q),
      .wr_uv  (wr_uv),
      .rd_col (col_cnt),
      .rd_uv  (rd_uv)
   );

   // left neighbours on this row and on the row above
   always_ff @(posedge clk) begin
      if (item_is_pixel) begin
         left_uv    <= wr_uv;
         up_left_uv <= rd_uv;
      end
   end

   // 2x2 sums, floored divide by 4 below
   assign u_sum = {2'b00, up_left_uv.u} + {2'b00, rd_uv.u} + {2'b00, left_uv.u}
                + {2'b00, item_q.u};
   assign v_sum = {2'b00, up_left_uv.v} + {2'b00, rd_uv.v} + {2'b00, left_uv.v}
                + {2'b00, item_q.v};

   always_comb begin
      kout.dtype   = item_q.dtype;
      kout.y       = item_q.y;
      kout.u       = item_q.u;
      kout.v       = item_q.v;
      kout.raw     = item_q.raw;
      kout.u_ave   = u_sum[9:2];
      kout.v_ave   = v_sum[9:2];
      kout.dump_uv = row_phase && col_phase;
   end

endmodule

// ==== rtl/uv_line_buffer.sv ====
`timescale 1ns/100ps

module uv_line_buffer (
   input  logic                             clk,
   input  logic                             resetb,
   input  logic                             wr_en,
   input  logic [yuv420_pkg::col_width-1:0] col,
   input  yuv420_pkg::uv_t                  wr_uv,
   input  logic [yuv420_pkg::col_width-1:0] rd_col,
   output yuv420_pkg::uv_t                  rd_uv
);

   // one row of u,v pairs, indexed by column
   yuv420_pkg::uv_t mem [yuv420_pkg::max_cols];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[col] <= wr_uv;
      end
   end

   // synchronous read, data is valid the cycle after rd_col
   // a write to the same column in the same cycle returns the old entry
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rd_uv <= '0;
      end else begin
         rd_uv <= mem[rd_col];
      end
   end

endmodule

// ==== rtl/yuv420_pkg.sv ====
package yuv420_pkg;

   // stream marker codes
   typedef enum logic [2:0] {
      dtype_frame_start = 3'd0,
      dtype_row_start   = 3'd1,
      dtype_pixel       = 3'd2,
      dtype_row_end     = 3'd3,
      dtype_frame_end   = 3'd4
   } dtype_t;

   // widest supported row
   localparam int max_cols = 1288;
   localparam int col_width = $clog2(max_cols);

   // low bits dropped from the raw sample to get one byte
   localparam int raw_pixel_shift = 8;

   // output word and byte buffer sizes
   localparam int word_width = 32;
   // one word plus one full yuv triple
   localparam int obuf_width = word_width + 24;
   localparam int fill_width = $clog2(obuf_width);

   // one item on the input stream
   typedef struct packed {
      dtype_t      dtype;
      logic [7:0]  y;
      logic [7:0]  u;
      logic [7:0]  v;
      logic [15:0] raw;
   } pixel_in_t;

   // item after the kernel stage, aligned with its chroma averages
   typedef struct packed {
      dtype_t      dtype;
      logic [7:0]  y;
      logic [7:0]  u;
      logic [7:0]  v;
      logic [15:0] raw;
      logic [7:0]  u_ave;
      logic [7:0]  v_ave;
      // odd row and odd column, the 2x2 averages go out after y
      logic        dump_uv;
   } kernel_out_t;

   // one line buffer entry
   typedef struct packed {
      logic [7:0] u;
      logic [7:0] v;
   } uv_t;

endpackage
